/* source/csr_pkg.sv */
// Machine-mode CSRs for RV32 with M and U privilege only; no delegation, PMP or HPM counters
package csr_pkg;

    ////////////////////////////////////////////////////////////
    // Addresses and encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [11:0] {
        MSTATUS   = 12'h300,
        MISA      = 12'h301,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82,
        CYCLE     = 12'hC00,    // User aliases, read only
        INSTRET   = 12'hC02,
        CYCLEH    = 12'hC80,
        INSTRETH  = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2
    } csr_op_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        INSTRUCTION_ACCESS_FAULT       = 5'd1,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ADDRESS_MISALIGNED        = 5'd4,
        LOAD_ACCESS_FAULT              = 5'd5,
        STORE_AMO_ADDRESS_MISALIGNED   = 5'd6,
        STORE_AMO_ACCESS_FAULT         = 5'd7,
        ECALL_FROM_UMODE               = 5'd8,
        ECALL_FROM_MMODE               = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    ////////////////////////////////////////////////////////////
    // Constants and masks
    ////////////////////////////////////////////////////////////

    parameter logic [31:0] MISA_VALUE   = 32'h4010_0100;  // MXL=1, U, I
    parameter logic [31:0] MSTATUS_MASK = 32'h0000_1888;  // MPP, MPIE, MIE
    parameter logic [31:0] MIE_MASK     = 32'h0000_0888;
    parameter logic [31:0] ALIGN_MASK   = 32'hFFFF_FFFC;

    parameter int MIE_BIT  = 3;
    parameter int MPIE_BIT = 7;
    parameter int MPP_LSB  = 11;

    ////////////////////////////////////////////////////////////
    // Port structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        read_en;
        logic        write_en;
        logic        killed;
        csr_op_e     op;
        csr_addr_e   addr;
        logic [31:0] data;
    } csr_req_t;

    typedef struct packed {
        logic        raise_exception;
        exc_code_e   exception_code;
        logic        mret;
        logic        interrupt_ack;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic        jump;
        logic [31:0] jump_target;
    } trap_req_t;

    // Already merged and masked
    typedef struct packed {
        logic        valid;
        csr_addr_e   addr;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtval;
    } trap_regs_t;

    typedef struct packed {
        logic [63:0] mcycle;
        logic [63:0] minstret;
    } counters_t;

endpackage

/* source/csr_access.sv */
// Purely combinational; unknown or read-only addresses read as listed and take no write
`timescale 1ns/1ns

module csr_access (
    input  csr_pkg::csr_req_t   req_i,
    input  csr_pkg::trap_regs_t regs_i,
    input  csr_pkg::counters_t  cnt_i,
    input  logic [31:0]         mip_i,
    output logic [31:0]         rdata_o,
    output csr_pkg::csr_write_t wr_o
);

    logic [31:0] cur_val;   // Present content of the addressed CSR
    logic [31:0] wmask;
    logic [31:0] merged;

    ////////////////////////////////////////////////////////////
    // Current value
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.addr)
            csr_pkg::MSTATUS:   cur_val = regs_i.mstatus;
            csr_pkg::MISA:      cur_val = csr_pkg::MISA_VALUE;
            csr_pkg::MIE:       cur_val = regs_i.mie;
            csr_pkg::MTVEC:     cur_val = regs_i.mtvec;
            csr_pkg::MSCRATCH:  cur_val = regs_i.mscratch;
            csr_pkg::MEPC:      cur_val = regs_i.mepc;
            csr_pkg::MCAUSE:    cur_val = regs_i.mcause;
            csr_pkg::MTVAL:     cur_val = regs_i.mtval;
            csr_pkg::MIP:       cur_val = mip_i;
            // User counter reads alias the machine counters
            csr_pkg::MCYCLE,
            csr_pkg::CYCLE:     cur_val = cnt_i.mcycle[31:0];
            csr_pkg::MCYCLEH,
            csr_pkg::CYCLEH:    cur_val = cnt_i.mcycle[63:32];
            csr_pkg::MINSTRET,
            csr_pkg::INSTRET:   cur_val = cnt_i.minstret[31:0];
            csr_pkg::MINSTRETH,
            csr_pkg::INSTRETH:  cur_val = cnt_i.minstret[63:32];
            default:            cur_val = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write masks
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.addr)
            csr_pkg::MSTATUS:   wmask = csr_pkg::MSTATUS_MASK;
            csr_pkg::MIE:       wmask = csr_pkg::MIE_MASK;
            csr_pkg::MTVEC,
            csr_pkg::MEPC:      wmask = csr_pkg::ALIGN_MASK;   // Word aligned
            csr_pkg::MSCRATCH,
            csr_pkg::MCAUSE,
            csr_pkg::MTVAL,
            csr_pkg::MCYCLE,
            csr_pkg::MCYCLEH,
            csr_pkg::MINSTRET,
            csr_pkg::MINSTRETH: wmask = '1;
            default:            wmask = '0;    // MISA, MIP, user aliases
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write, set, clear merge
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            csr_pkg::CSR_SET:   merged = cur_val | req_i.data;
            csr_pkg::CSR_CLEAR: merged = cur_val & ~req_i.data;
            default:            merged = req_i.data;
        endcase
    end

    assign wr_o.valid = req_i.write_en && !req_i.killed;
    assign wr_o.addr  = req_i.addr;
    assign wr_o.data  = merged & wmask;

    // Read port, gated by the kill
    assign rdata_o = (req_i.read_en && !req_i.killed) ? cur_val : '0;

endmodule

/* source/trap_state.sv */
// Only MIE, MPIE and MPP exist in MSTATUS; MPP accepts any 2-bit value written to it
`timescale 1ns/1ns

module trap_state #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::csr_write_t wr_i,
    input  csr_pkg::trap_req_t  trap_i,
    input  csr_pkg::irq_code_e  irq_code_i,
    output csr_pkg::trap_regs_t regs_o,
    output csr_pkg::priv_e      privilege_o
);

    logic           mstatus_mie;
    logic           mstatus_mpie;
    logic [1:0]     mstatus_mpp;
    logic [31:0]    mie, mtvec, mscratch, mepc, mcause, mtval;
    csr_pkg::priv_e privilege;

    ////////////////////////////////////////////////////////////
    // State update, mret > exception > interrupt > CSR write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= 2'b00;
            mie          <= '0;
            mtvec        <= MTVEC_RESET;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            privilege    <= csr_pkg::PRIV_M;
        end
        else if (trap_i.mret) begin
            mstatus_mie <= mstatus_mpie;
            privilege   <= csr_pkg::priv_e'(mstatus_mpp);
        end
        else if (trap_i.raise_exception) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= privilege;
            privilege    <= csr_pkg::PRIV_M;
            mepc         <= trap_i.pc;
            mcause       <= {27'b0, trap_i.exception_code};    // Bit 31 clear
            mtval        <= (trap_i.exception_code == csr_pkg::ILLEGAL_INSTRUCTION)
                            ? trap_i.instruction
                            : trap_i.pc;
        end
        else if (trap_i.interrupt_ack) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= privilege;
            privilege    <= csr_pkg::PRIV_M;
            mcause       <= {1'b1, 26'b0, irq_code_i};
            // Current instruction retires, so return to its successor
            mepc         <= trap_i.jump ? trap_i.jump_target : trap_i.pc + 32'd4;
        end
        else if (wr_i.valid) begin
            case (wr_i.addr)
                csr_pkg::MSTATUS: begin
                    mstatus_mie  <= wr_i.data[csr_pkg::MIE_BIT];
                    mstatus_mpie <= wr_i.data[csr_pkg::MPIE_BIT];
                    mstatus_mpp  <= wr_i.data[csr_pkg::MPP_LSB +: 2];
                end
                csr_pkg::MIE:      mie      <= wr_i.data;
                csr_pkg::MTVEC:    mtvec    <= wr_i.data;
                csr_pkg::MSCRATCH: mscratch <= wr_i.data;
                csr_pkg::MEPC:     mepc     <= wr_i.data;
                csr_pkg::MCAUSE:   mcause   <= wr_i.data;
                csr_pkg::MTVAL:    mtval    <= wr_i.data;
                default: ;  // Not held here
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Register view
    ////////////////////////////////////////////////////////////

    always_comb begin
        regs_o.mstatus                          = '0;
        regs_o.mstatus[csr_pkg::MIE_BIT]        = mstatus_mie;
        regs_o.mstatus[csr_pkg::MPIE_BIT]       = mstatus_mpie;
        regs_o.mstatus[csr_pkg::MPP_LSB +: 2]   = mstatus_mpp;
        regs_o.mie                              = mie;
        regs_o.mtvec                            = mtvec;
        regs_o.mscratch                         = mscratch;
        regs_o.mepc                             = mepc;
        regs_o.mcause                           = mcause;
        regs_o.mtval                            = mtval;
    end

    assign privilege_o = privilege;

endmodule

/* source/cycle_counters.sv */
// Both counters wrap at 2^64; a half-word write wins over the increment of that half only
`timescale 1ns/1ns

module cycle_counters (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::csr_write_t wr_i,
    input  logic                killed_i,
    output csr_pkg::counters_t  cnt_o
);

    logic [63:0] mcycle, minstret;

    // Increment, then let a CSR write replace the addressed half
    function automatic logic [63:0] count_next(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] data
    );
        logic [63:0] nxt;
        nxt = cur + 64'(inc);
        if (wr_lo)
            nxt[31:0] = data;
        if (wr_hi)
            nxt[63:32] = data;
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end
        else begin
            mcycle   <= count_next(mcycle, 1'b1,
                                   wr_i.valid && wr_i.addr == csr_pkg::MCYCLE,
                                   wr_i.valid && wr_i.addr == csr_pkg::MCYCLEH,
                                   wr_i.data);
            minstret <= count_next(minstret, !killed_i,     // Retired when not killed
                                   wr_i.valid && wr_i.addr == csr_pkg::MINSTRET,
                                   wr_i.valid && wr_i.addr == csr_pkg::MINSTRETH,
                                   wr_i.data);
        end
    end

    assign cnt_o.mcycle   = mcycle;
    assign cnt_o.minstret = minstret;

endmodule

/* source/interrupt_unit.sv */
// Level-sensitive irq lines; pending follows irq_i by two cycles and drops on acknowledge
`timescale 1ns/1ns

module interrupt_unit (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [31:0]        irq_i,
    input  logic               mstatus_mie_i,
    input  logic [31:0]        mie_i,
    input  logic               interrupt_ack_i,
    output logic [31:0]        mip_o,
    output logic               pending_o,
    output csr_pkg::irq_code_e irq_code_o
);

    logic [31:0] mip;
    logic [31:0] active;    // Pending and enabled
    logic        raise;

    assign active = mip & mie_i;
    assign raise  = mstatus_mie_i && (active != '0) && !interrupt_ack_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip       <= '0;
            pending_o <= 1'b0;
        end
        else begin
            mip       <= irq_i;
            pending_o <= raise;
        end
    end

    // Cause held until the next raise, external first
    always_ff @(posedge clk) begin
        if (raise) begin
            if (active[11])
                irq_code_o <= csr_pkg::M_EXT_INT;
            else if (active[3])
                irq_code_o <= csr_pkg::M_SW_INT;
            else if (active[7])
                irq_code_o <= csr_pkg::M_TIM_INT;
        end
    end

    assign mip_o = mip;

endmodule

/* source/csr_bank.sv */
// CSR reads are combinational; writes, traps and mret take effect on the next clock edge
`timescale 1ns/1ns

module csr_bank #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 reset_n,

    input  csr_pkg::csr_req_t    req_i,
    input  csr_pkg::trap_req_t   trap_i,
    input  logic [31:0]          irq_i,

    output logic [31:0]          rdata_o,
    output logic                 interrupt_pending_o,
    output csr_pkg::priv_e       privilege_o,
    output logic [31:0]          mepc_o,
    output logic [31:0]          mtvec_o
);

    csr_pkg::csr_write_t wr;        // Masked write to the state holders
    csr_pkg::trap_regs_t regs;
    csr_pkg::counters_t  cnt;
    logic [31:0]         mip;
    csr_pkg::irq_code_e  irq_code;

    assign mepc_o  = regs.mepc;
    assign mtvec_o = regs.mtvec;

    csr_access access0 (
        .req_i   (req_i),
        .regs_i  (regs),
        .cnt_i   (cnt),
        .mip_i   (mip),
        .rdata_o (rdata_o),
        .wr_o    (wr)
    );

    trap_state #(
        .MTVEC_RESET (MTVEC_RESET)
    ) trap0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_i        (wr),
        .trap_i      (trap_i),
        .irq_code_i  (irq_code),
        .regs_o      (regs),
        .privilege_o (privilege_o)
    );

    cycle_counters counters0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr_i     (wr),
        .killed_i (req_i.killed),   // Retire count follows the pipeline kill
        .cnt_o    (cnt)
    );

    interrupt_unit irq0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .irq_i           (irq_i),
        .mstatus_mie_i   (regs.mstatus[csr_pkg::MIE_BIT]),
        .mie_i           (regs.mie),
        .interrupt_ack_i (trap_i.interrupt_ack),
        .mip_o           (mip),
        .pending_o       (interrupt_pending_o),
        .irq_code_o      (irq_code)
    );

endmodule

/* tests/tb_csr_checks.sv */
// Value checks are called from the sequence; rdata_o is watched on each clock after reset
`timescale 1ns/1ns

module tb_csr_checks (
    input  logic              clk,
    input  logic              reset_n,
    input  csr_pkg::csr_req_t req_i,
    input  logic [31:0]       rdata_i
);

    int value_errors = 0;
    int other_errors = 0;

    ////////////////////////////////////////////////////////////
    // Checks called from the sequence
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            value_errors++;
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond)
        else begin
            other_errors++;
            $display("check failed: %s", what);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks on every clock
    ////////////////////////////////////////////////////////////

    // Gated read returns zero
    gated_read: assert property (@(posedge clk) disable iff (!reset_n)
        (!req_i.read_en || req_i.killed) |-> rdata_i == 32'h0)
    else begin
        value_errors++;
        $display("error rdata_o: got 0x%08h on a gated read, expected 0x00000000", rdata_i);
    end

    // Never X out of reset
    known_read: assert property (@(posedge clk) disable iff (!reset_n) !$isunknown(rdata_i))
    else begin
        other_errors++;
        $display("rdata_o has unknown bits after reset");
    end

    function automatic int total_errors();
        return value_errors + other_errors;
    endfunction

    task automatic report();
        $display("errors: %0d value, %0d other", value_errors, other_errors);
    endtask

endmodule

/* tests/tb_csr_bank.sv */
// Drives inputs on the falling edge; reads sample rdata_o 1 ns after the drive
`timescale 1ns/1ns

module tb_csr_bank;

    logic                clk;
    logic                reset_n;
    csr_pkg::csr_req_t   req;
    csr_pkg::trap_req_t  trap;
    logic [31:0]         irq;
    logic [31:0]         rdata;
    logic                pending;
    csr_pkg::priv_e      priv;
    logic [31:0]         mepc;
    logic [31:0]         mtvec;
    integer              seed = 46282;

    csr_bank dut0 (
        .clk                 (clk),
        .reset_n             (reset_n),
        .req_i               (req),
        .trap_i              (trap),
        .irq_i               (irq),
        .rdata_o             (rdata),
        .interrupt_pending_o (pending),
        .privilege_o         (priv),
        .mepc_o              (mepc),
        .mtvec_o             (mtvec)
    );

    tb_csr_checks chk0 (
        .clk     (clk),
        .reset_n (reset_n),
        .req_i   (req),
        .rdata_i (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Drive tasks
    ////////////////////////////////////////////////////////////

    task automatic read_csr(input csr_pkg::csr_addr_e addr, output logic [31:0] val);
        @(negedge clk);
        req         = '0;
        req.read_en = 1'b1;
        req.addr    = addr;
        #1 val = rdata;     // Combinational read
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_e addr, input csr_pkg::csr_op_e op,
                             input logic [31:0] data, input logic killed);
        @(negedge clk);
        req          = '0;
        req.write_en = 1'b1;
        req.killed   = killed;
        req.op       = op;
        req.addr     = addr;
        req.data     = data;
        @(negedge clk);
        req = '0;
    endtask

    task automatic pulse_trap(input csr_pkg::trap_req_t t);
        @(negedge clk);
        trap = t;
        @(negedge clk);
        trap = '0;
    endtask

    task automatic wait_pending();
        int cycles;
        cycles = 0;
        while (!pending && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        chk0.check_true(pending, "interrupt_pending_o did not rise within 20 cycles");
    endtask

    function automatic logic [31:0] merge_expect(input csr_pkg::csr_op_e op,
                                                 input logic [31:0] old, input logic [31:0] data);
        case (op)
            csr_pkg::CSR_SET:   return old | data;
            csr_pkg::CSR_CLEAR: return old & ~data;
            default:            return data;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        csr_pkg::csr_addr_e addrs[5];
        logic [31:0]        masks[5];
        csr_pkg::csr_op_e   ops[3];
        csr_pkg::exc_code_e codes[2];
        csr_pkg::trap_req_t t;
        logic [31:0]        old_val, new_val, exp_val, data, exp_st, c0, c1, r;
        int                 k;

        req     = '0;
        trap    = '0;
        irq     = '0;
        reset_n = 1'b0;
        addrs = '{csr_pkg::MSCRATCH, csr_pkg::MIE, csr_pkg::MTVEC, csr_pkg::MEPC,
                  csr_pkg::MSTATUS};
        masks = '{32'hFFFF_FFFF, csr_pkg::MIE_MASK, csr_pkg::ALIGN_MASK,
                  csr_pkg::ALIGN_MASK, csr_pkg::MSTATUS_MASK};
        ops   = '{csr_pkg::CSR_WRITE, csr_pkg::CSR_SET, csr_pkg::CSR_CLEAR};
        codes = '{csr_pkg::ILLEGAL_INSTRUCTION, csr_pkg::LOAD_ACCESS_FAULT};
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Masked write, set, clear
        foreach (addrs[a]) begin
            foreach (ops[o]) begin
                read_csr(addrs[a], old_val);
                data = $random(seed);
                write_csr(addrs[a], ops[o], data, 1'b0);
                read_csr(addrs[a], new_val);
                exp_val = merge_expect(ops[o], old_val, data) & masks[a];
                chk0.check_value(addrs[a].name(), new_val, exp_val);
                if (addrs[a] == csr_pkg::MTVEC)
                    chk0.check_value("mtvec_o", mtvec, exp_val);
            end
        end
        write_csr(csr_pkg::MISA, csr_pkg::CSR_WRITE, $random(seed), 1'b0);
        read_csr(csr_pkg::MISA, new_val);
        chk0.check_value("MISA", new_val, csr_pkg::MISA_VALUE);

        // Killed write and gated reads
        read_csr(csr_pkg::MSCRATCH, old_val);
        write_csr(csr_pkg::MSCRATCH, csr_pkg::CSR_WRITE, ~old_val, 1'b1);
        read_csr(csr_pkg::MSCRATCH, new_val);
        chk0.check_value("MSCRATCH after killed write", new_val, old_val);
        @(negedge clk);
        req      = '0;
        req.addr = csr_pkg::MSCRATCH;
        #1 chk0.check_value("rdata_o read_en low", rdata, 32'h0);
        @(negedge clk);
        req.read_en = 1'b1;
        req.killed  = 1'b1;
        #1 chk0.check_value("rdata_o killed", rdata, 32'h0);
        read_csr(csr_pkg::csr_addr_e'(12'h7C0), new_val);
        chk0.check_value("rdata_o unlisted address", new_val, 32'h0);

        // Exception entry from M with MIE set and MPP at U
        foreach (codes[i]) begin
            write_csr(csr_pkg::MSTATUS, csr_pkg::CSR_WRITE, 32'h0000_0008, 1'b0);
            t                 = '0;
            t.raise_exception = 1'b1;
            t.exception_code  = codes[i];
            t.pc              = $random(seed);
            t.instruction     = $random(seed);
            pulse_trap(t);
            read_csr(csr_pkg::MEPC, new_val);
            chk0.check_value("MEPC", new_val, t.pc);
            chk0.check_value("mepc_o", mepc, t.pc);
            read_csr(csr_pkg::MCAUSE, new_val);
            chk0.check_value("MCAUSE", new_val, {27'b0, codes[i]});
            read_csr(csr_pkg::MTVAL, new_val);
            chk0.check_value("MTVAL", new_val,
                             (codes[i] == csr_pkg::ILLEGAL_INSTRUCTION) ? t.instruction : t.pc);
            exp_st        = '0;
            exp_st[7]     = 1'b1;               // MPIE takes the old MIE
            exp_st[12:11] = csr_pkg::PRIV_M;    // Still M, no mret yet
            read_csr(csr_pkg::MSTATUS, new_val);
            chk0.check_value("MSTATUS", new_val, exp_st);
            chk0.check_value("privilege_o", {30'b0, priv}, {30'b0, csr_pkg::PRIV_M});
        end

        // Interrupt entry, both return targets, then mret
        write_csr(csr_pkg::MIE, csr_pkg::CSR_WRITE, 32'h0000_0800, 1'b0);
        write_csr(csr_pkg::MSTATUS, csr_pkg::CSR_SET, 32'h0000_0008, 1'b0);
        @(negedge clk);
        irq[11] = 1'b1;
        wait_pending();
        for (int j = 0; j < 2; j++) begin
            t               = '0;
            t.interrupt_ack = 1'b1;
            t.pc            = $random(seed);
            t.jump          = (j == 1);
            t.jump_target   = $random(seed);
            pulse_trap(t);
            read_csr(csr_pkg::MCAUSE, new_val);
            chk0.check_value("MCAUSE interrupt", new_val, 32'h8000_000B);
            read_csr(csr_pkg::MEPC, new_val);
            chk0.check_value("MEPC interrupt", new_val, t.jump ? t.jump_target : t.pc + 32'd4);
        end
        @(negedge clk);
        irq = '0;
        write_csr(csr_pkg::MSTATUS, csr_pkg::CSR_WRITE, 32'h0000_0080, 1'b0);  // MPP = U, MPIE set
        t      = '0;
        t.mret = 1'b1;
        pulse_trap(t);
        read_csr(csr_pkg::MSTATUS, new_val);
        chk0.check_value("MSTATUS.MIE after mret", {31'b0, new_val[3]}, 32'h1);
        chk0.check_value("privilege_o after mret", {30'b0, priv}, {30'b0, csr_pkg::PRIV_U});

        // Trap taken from U
        t                 = '0;
        t.raise_exception = 1'b1;
        t.exception_code  = csr_pkg::ECALL_FROM_UMODE;
        t.pc              = $random(seed);
        pulse_trap(t);
        read_csr(csr_pkg::MSTATUS, new_val);
        chk0.check_value("MSTATUS.MPP from U", {30'b0, new_val[12:11]},
                         {30'b0, csr_pkg::PRIV_U});
        chk0.check_value("privilege_o after trap from U", {30'b0, priv},
                         {30'b0, csr_pkg::PRIV_M});

        // Counters over a 10 cycle window
        read_csr(csr_pkg::CYCLE, c0);
        repeat (9) @(negedge clk);
        read_csr(csr_pkg::CYCLE, c1);
        chk0.check_value("CYCLE delta", c1 - c0, 32'd10);
        read_csr(csr_pkg::INSTRET, c0);
        k = 0;
        repeat (9) begin
            @(negedge clk);
            r          = $random(seed);
            req        = '0;
            req.killed = r[0];
            if (r[0])
                k++;
        end
        read_csr(csr_pkg::INSTRET, c1);
        chk0.check_value("INSTRET delta", c1 - c0, 10 - k);
        data = $random(seed);
        write_csr(csr_pkg::MCYCLEH, csr_pkg::CSR_WRITE, data, 1'b0);
        read_csr(csr_pkg::MCYCLEH, new_val);
        chk0.check_value("MCYCLEH", new_val, data);
        data = $random(seed);
        write_csr(csr_pkg::MINSTRETH, csr_pkg::CSR_WRITE, data, 1'b0);
        read_csr(csr_pkg::MINSTRETH, new_val);
        chk0.check_value("MINSTRETH", new_val, data);

        chk0.report();
        if (chk0.total_errors() == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* vlog.f */
source/csr_pkg.sv
source/csr_access.sv
source/trap_state.sv
source/cycle_counters.sv
source/interrupt_unit.sv
source/csr_bank.sv
tests/tb_csr_checks.sv
tests/tb_csr_bank.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_bank
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
